/* rtl/doc_macros.svh */
// Wavetable generator sizing
// Oscillator slot count and phase accumulator width
`ifndef DOC_MACROS_SVH
`define DOC_MACROS_SVH

// Number of oscillator slots
`define DOC_OSC_COUNT 8

// Phase accumulator width, top byte indexes the 256-byte table
`define DOC_ACC_WIDTH 24

`endif

/* rtl/doc_pkg.sv */
// Wavetable generator types
// Sequencer states, control modes and the structs passed between blocks
`include "doc_macros.svh"

package doc_pkg;

    typedef enum logic [2:0] {
        IDLE,
        ACCUM,
        FETCH,
        SCALE,
        NEXT
    } osc_state_e;

    // Reserved codes behave as free run
    typedef enum logic [1:0] {
        FREE_RUN   = 2'b00,
        ONE_SHOT   = 2'b01,
        MODE_RSVD2 = 2'b10,
        MODE_RSVD3 = 2'b11
    } osc_mode_e;

    // Per-oscillator parameters from the regfile
    typedef struct packed {
        logic [15:0] frequency;
        logic [7:0]  volume;
        logic [7:0]  table_ptr;
        logic        halt;
        osc_mode_e   mode;
        logic        irq_en;
        logic        channel;
    } osc_params_t;

    // Slot result reported back to the regfile
    typedef struct packed {
        logic       valid;
        logic [4:0] osc_idx;
        logic       set_halt;
        logic       irq;
        logic [7:0] last_sample;
    } osc_update_t;

    // One scaled voice for the mixer
    typedef struct packed {
        logic               valid;
        logic               frame_last;
        logic               channel;
        logic signed [15:0] sample;
    } voice_t;

    // Live sequencer state for the debug snapshot
    typedef struct packed {
        logic [4:0]                osc;
        osc_state_e                state;
        logic [7:0]                volume;
        logic [7:0]                wds;
        logic signed [15:0]        out;
        logic [`DOC_ACC_WIDTH-1:0] acc;
    } debug_t;

endpackage

/* rtl/doc_regfile.sv */
// Oscillator register file on the CPU byte bus
// Holds per-oscillator parameters, the interrupt queue and the read mux
`include "doc_macros.svh"

module doc_regfile
    import doc_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        cs_n_i,
    input  logic        we_n_i,
    input  logic [7:0]  addr_i,
    input  logic [7:0]  data_i,
    output logic [7:0]  data_o,
    input  logic [4:0]  osc_sel_i,
    output osc_params_t params_o,
    output logic [4:0]  osc_last_o,
    input  osc_update_t update_i,
    output logic        irq_n_o
);
    localparam int IDX_W = $clog2(`DOC_OSC_COUNT);

    logic [7:0] freq_lo_q [`DOC_OSC_COUNT];
    logic [7:0] freq_hi_q [`DOC_OSC_COUNT];
    logic [7:0] vol_q [`DOC_OSC_COUNT];
    logic [7:0] last_q [`DOC_OSC_COUNT];
    logic [7:0] ptr_q [`DOC_OSC_COUNT];
    logic [4:0] ctrl_q [`DOC_OSC_COUNT];
    logic [4:0] osc_last_q;

    // Pending interrupt queue, one entry per oscillator is enough
    logic [4:0]       irq_fifo_q [`DOC_OSC_COUNT];
    logic [IDX_W-1:0] irq_wr_q;
    logic [IDX_W-1:0] irq_rd_q;
    logic [IDX_W:0]   irq_cnt_q;

    logic             bus_wr;
    logic             bus_rd;
    logic             bus_in_range;
    logic [IDX_W-1:0] bus_idx;
    logic [IDX_W-1:0] sel_idx;
    logic [IDX_W-1:0] upd_idx;
    logic             irq_empty;
    logic             irq_push;
    logic             irq_pop;
    logic [7:0]       rd_data;

    assign bus_wr       = !cs_n_i && !we_n_i;
    assign bus_rd       = !cs_n_i && we_n_i;
    assign bus_in_range = addr_i[4:0] < `DOC_OSC_COUNT;
    assign bus_idx      = addr_i[IDX_W-1:0];
    assign sel_idx      = osc_sel_i[IDX_W-1:0];
    assign upd_idx      = update_i.osc_idx[IDX_W-1:0];

    assign irq_empty = irq_cnt_q == '0;
    assign irq_push  = update_i.valid && update_i.irq && irq_cnt_q != `DOC_OSC_COUNT;
    assign irq_pop   = bus_rd && addr_i == 8'hE0 && !irq_empty;
    assign irq_n_o   = irq_empty;

    // Count above the number of slots is clamped
    assign osc_last_o = (osc_last_q > 5'(`DOC_OSC_COUNT - 1)) ?
                        5'(`DOC_OSC_COUNT - 1) : osc_last_q;

    // Combinational parameter read for the sequencer
    always_comb begin
        params_o = '0;
        if (osc_sel_i < `DOC_OSC_COUNT) begin
            params_o.frequency = {freq_hi_q[sel_idx], freq_lo_q[sel_idx]};
            params_o.volume    = vol_q[sel_idx];
            params_o.table_ptr = ptr_q[sel_idx];
            params_o.halt      = ctrl_q[sel_idx][0];
            params_o.mode      = osc_mode_e'(ctrl_q[sel_idx][2:1]);
            params_o.irq_en    = ctrl_q[sel_idx][3];
            params_o.channel   = ctrl_q[sel_idx][4];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `DOC_OSC_COUNT; i++) begin
                freq_lo_q[i] <= '0;
                freq_hi_q[i] <= '0;
                vol_q[i]     <= '0;
                last_q[i]    <= '0;
                ptr_q[i]     <= '0;
                ctrl_q[i]    <= '0;
            end
            osc_last_q <= '0;
        end else begin
            if (bus_wr && bus_in_range) begin
                case (addr_i[7:5])
                    3'd0: freq_lo_q[bus_idx] <= data_i;
                    3'd1: freq_hi_q[bus_idx] <= data_i;
                    3'd2: vol_q[bus_idx]     <= data_i;
                    3'd4: ptr_q[bus_idx]     <= data_i;
                    3'd5: ctrl_q[bus_idx]    <= data_i[4:0];
                    default: ;
                endcase
            end
            if (bus_wr && addr_i == 8'hE1) begin
                osc_last_q <= data_i[4:0];
            end
            // Sequencer result lands after the bus write, so its halt wins
            if (update_i.valid) begin
                last_q[upd_idx] <= update_i.last_sample;
                if (update_i.set_halt) begin
                    ctrl_q[upd_idx][0] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            irq_wr_q  <= '0;
            irq_rd_q  <= '0;
            irq_cnt_q <= '0;
            for (int i = 0; i < `DOC_OSC_COUNT; i++) begin
                irq_fifo_q[i] <= '0;
            end
        end else begin
            if (irq_push) begin
                irq_fifo_q[irq_wr_q] <= update_i.osc_idx;
                irq_wr_q             <= irq_wr_q + 1'b1;
            end
            if (irq_pop) begin
                irq_rd_q <= irq_rd_q + 1'b1;
            end
            case ({irq_push, irq_pop})
                2'b10:   irq_cnt_q <= irq_cnt_q + 1'b1;
                2'b01:   irq_cnt_q <= irq_cnt_q - 1'b1;
                default: ;
            endcase
        end
    end

    // Read mux, bit7 of 0xE0 flags an empty queue
    always_comb begin
        rd_data = '0;
        if (addr_i == 8'hE0) begin
            rd_data = {irq_empty, 2'b00, irq_fifo_q[irq_rd_q]};
        end else if (addr_i == 8'hE1) begin
            rd_data = {3'b000, osc_last_q};
        end else if (bus_in_range) begin
            case (addr_i[7:5])
                3'd0:    rd_data = freq_lo_q[bus_idx];
                3'd1:    rd_data = freq_hi_q[bus_idx];
                3'd2:    rd_data = vol_q[bus_idx];
                3'd3:    rd_data = last_q[bus_idx];
                3'd4:    rd_data = ptr_q[bus_idx];
                3'd5:    rd_data = {3'b000, ctrl_q[bus_idx]};
                default: rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_o <= '0;
        end else if (bus_rd) begin
            data_o <= rd_data;
        end
    end

endmodule

/* rtl/doc_osc_sequencer.sv */
// Round-robin oscillator engine
// Advances each phase accumulator, fetches a wave byte and scales it by volume
`include "doc_macros.svh"

module doc_osc_sequencer
    import doc_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        clk_en_i,
    output logic [4:0]  osc_sel_o,
    input  osc_params_t params_i,
    input  logic [4:0]  osc_last_i,
    output osc_update_t update_o,
    output logic [15:0] wave_address_o,
    output logic        wave_rd_o,
    input  logic        wave_data_ready_i,
    input  logic [7:0]  wave_data_i,
    output voice_t      voice_o,
    output debug_t      debug_o
);
    localparam int IDX_W = $clog2(`DOC_OSC_COUNT);
    localparam int ACC_W = `DOC_ACC_WIDTH;

    osc_state_e         state_q;
    logic [4:0]         cur_q;
    logic [4:0]         nxt_osc;
    logic [IDX_W-1:0]   cur_idx;
    logic [ACC_W-1:0]   acc_q [`DOC_OSC_COUNT];
    logic [ACC_W:0]     acc_sum;
    logic [7:0]         vol_q;
    logic [7:0]         wds_q;
    logic               skip_q;
    logic               wrap_q;
    logic signed [15:0] out_q;
    logic signed [8:0]  centered;
    logic signed [17:0] product;
    logic               end_of_table;
    logic signed [15:0] scaled;
    logic               frame_last;

    assign cur_idx    = cur_q[IDX_W-1:0];
    assign frame_last = cur_q >= osc_last_i;
    assign nxt_osc    = frame_last ? 5'd0 : cur_q + 5'd1;

    // In NEXT the regfile is already looking at the upcoming oscillator
    assign osc_sel_o = (state_q == NEXT) ? nxt_osc : cur_q;

    assign acc_sum = {1'b0, acc_q[cur_idx]} + (ACC_W + 1)'(params_i.frequency);

    // Wave byte is offset binary around 128
    assign centered = $signed({1'b0, wds_q}) - 9'sd128;
    assign product  = centered * $signed({1'b0, vol_q});

    // Byte 0 or a one-shot wrap ends the table
    assign end_of_table = !skip_q && (wds_q == 8'h00 || wrap_q);
    assign scaled       = (skip_q || end_of_table) ? 16'sd0 : product[15:0];

    always_comb begin
        voice_o            = '0;
        voice_o.valid      = state_q == SCALE && clk_en_i;
        voice_o.frame_last = frame_last;
        voice_o.channel    = params_i.channel;
        voice_o.sample     = scaled;
    end

    // Halted slots leave the last sample register alone
    always_comb begin
        update_o             = '0;
        update_o.valid       = state_q == SCALE && clk_en_i && !skip_q;
        update_o.osc_idx     = cur_q;
        update_o.set_halt    = end_of_table;
        update_o.irq         = end_of_table && params_i.irq_en;
        update_o.last_sample = wds_q;
    end

    always_comb begin
        debug_o        = '0;
        debug_o.osc    = cur_q;
        debug_o.state  = state_q;
        debug_o.volume = vol_q;
        debug_o.wds    = wds_q;
        debug_o.out    = out_q;
        debug_o.acc    = acc_q[cur_idx];
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q        <= IDLE;
            cur_q          <= '0;
            vol_q          <= '0;
            wds_q          <= '0;
            skip_q         <= 1'b0;
            wrap_q         <= 1'b0;
            out_q          <= '0;
            wave_rd_o      <= 1'b0;
            wave_address_o <= '0;
            for (int i = 0; i < `DOC_OSC_COUNT; i++) begin
                acc_q[i] <= '0;
            end
        end else if (clk_en_i) begin
            case (state_q)
                // Dispatch a slot, halted ones go straight to SCALE
                IDLE, NEXT: begin
                    cur_q   <= osc_sel_o;
                    vol_q   <= params_i.volume;
                    skip_q  <= params_i.halt;
                    wrap_q  <= 1'b0;
                    state_q <= params_i.halt ? SCALE : ACCUM;
                end
                ACCUM: begin
                    acc_q[cur_idx] <= acc_sum[ACC_W-1:0];
                    wrap_q         <= acc_sum[ACC_W] && params_i.mode == ONE_SHOT;
                    // Table page in the high byte, phase top byte in the low byte
                    wave_address_o <= {params_i.table_ptr, acc_sum[ACC_W-1 -: 8]};
                    wave_rd_o      <= 1'b1;
                    state_q        <= FETCH;
                end
                FETCH: begin
                    // Hold strobe and address until memory answers
                    if (wave_data_ready_i) begin
                        wds_q     <= wave_data_i;
                        wave_rd_o <= 1'b0;
                        state_q   <= SCALE;
                    end
                end
                SCALE: begin
                    out_q   <= scaled;
                    state_q <= NEXT;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

/* rtl/doc_mixer.sv */
// Voice mixer
// Sums one frame of voices and saturates to mono, left and right outputs
`include "doc_macros.svh"

module doc_mixer
    import doc_pkg::*;
(
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  voice_t             voice_i,
    output logic signed [15:0] mono_mix_o,
    output logic signed [15:0] left_mix_o,
    output logic signed [15:0] right_mix_o,
    output logic               frame_o
);
    // Headroom for a full frame of full-scale voices
    localparam int SUM_W = 17 + $clog2(`DOC_OSC_COUNT);

    logic signed [SUM_W-1:0] mono_q;
    logic signed [SUM_W-1:0] left_q;
    logic signed [SUM_W-1:0] right_q;
    logic signed [SUM_W-1:0] voice_ext;
    logic signed [SUM_W-1:0] mono_sum;
    logic signed [SUM_W-1:0] left_sum;
    logic signed [SUM_W-1:0] right_sum;

    function automatic logic signed [15:0] sat16(input logic signed [SUM_W-1:0] v);
        if (v > SUM_W'(32767)) begin
            return 16'sh7FFF;
        end else if (v < -SUM_W'(32768)) begin
            return 16'sh8000;
        end
        return v[15:0];
    endfunction

    assign voice_ext = {{(SUM_W - 16){voice_i.sample[15]}}, voice_i.sample};

    // Channel 0 feeds left, channel 1 feeds right, mono takes all
    always_comb begin
        mono_sum  = mono_q + voice_ext;
        left_sum  = left_q;
        right_sum = right_q;
        if (voice_i.channel) begin
            right_sum = right_q + voice_ext;
        end else begin
            left_sum = left_q + voice_ext;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mono_q      <= '0;
            left_q      <= '0;
            right_q     <= '0;
            mono_mix_o  <= '0;
            left_mix_o  <= '0;
            right_mix_o <= '0;
            frame_o     <= 1'b0;
        end else begin
            frame_o <= 1'b0;
            if (voice_i.valid) begin
                if (voice_i.frame_last) begin
                    // Publish the frame and start the next one from zero
                    mono_mix_o  <= sat16(mono_sum);
                    left_mix_o  <= sat16(left_sum);
                    right_mix_o <= sat16(right_sum);
                    frame_o     <= 1'b1;
                    mono_q      <= '0;
                    left_q      <= '0;
                    right_q     <= '0;
                end else begin
                    mono_q  <= mono_sum;
                    left_q  <= left_sum;
                    right_q <= right_sum;
                end
            end
        end
    end

endmodule

/* rtl/doc_synth_harness.sv */
// Wavetable generator top level
// Connects regfile, sequencer and mixer and registers a debug snapshot
module doc_synth_harness
    import doc_pkg::*;
(
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               clk_en_i,
    input  logic               cs_n_i,
    input  logic               we_n_i,
    input  logic [7:0]         addr_i,
    input  logic [7:0]         data_i,
    output logic [7:0]         data_o,
    output logic [15:0]        wave_address_o,
    output logic               wave_rd_o,
    input  logic               wave_data_ready_i,
    input  logic [7:0]         wave_data_i,
    output logic               irq_n_o,
    output logic signed [15:0] mono_mix_o,
    output logic signed [15:0] left_mix_o,
    output logic signed [15:0] right_mix_o,
    output logic               dbg_frame_o,
    output logic [4:0]         dbg_osc_o,
    output osc_state_e         dbg_state_o,
    output logic [7:0]         dbg_vol_o,
    output logic [7:0]         dbg_wds_o,
    output logic signed [15:0] dbg_output_o
);
    logic [4:0]  osc_sel;
    logic [4:0]  osc_last;
    osc_params_t params;
    osc_update_t update;
    voice_t      voice;
    debug_t      debug;
    debug_t      debug_q;

    doc_regfile regfile_i (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .cs_n_i    (cs_n_i),
        .we_n_i    (we_n_i),
        .addr_i    (addr_i),
        .data_i    (data_i),
        .data_o    (data_o),
        .osc_sel_i (osc_sel),
        .params_o  (params),
        .osc_last_o(osc_last),
        .update_i  (update),
        .irq_n_o   (irq_n_o)
    );

    doc_osc_sequencer sequencer_i (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .clk_en_i         (clk_en_i),
        .osc_sel_o        (osc_sel),
        .params_i         (params),
        .osc_last_i       (osc_last),
        .update_o         (update),
        .wave_address_o   (wave_address_o),
        .wave_rd_o        (wave_rd_o),
        .wave_data_ready_i(wave_data_ready_i),
        .wave_data_i      (wave_data_i),
        .voice_o          (voice),
        .debug_o          (debug)
    );

    doc_mixer mixer_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .voice_i    (voice),
        .mono_mix_o (mono_mix_o),
        .left_mix_o (left_mix_o),
        .right_mix_o(right_mix_o),
        .frame_o    (dbg_frame_o)
    );

    // Snapshot of the slot being served, one cycle behind the core
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            debug_q <= '0;
        end else begin
            debug_q <= debug;
        end
    end

    assign dbg_osc_o    = debug_q.osc;
    assign dbg_state_o  = debug_q.state;
    assign dbg_vol_o    = debug_q.volume;
    assign dbg_wds_o    = debug_q.wds;
    assign dbg_output_o = debug_q.out;

endmodule

/* bench/wave_mem_model.sv */
// Wave memory responder for the wavetable generator testbench
// Answers each read strobe after a random delay, data follows the table rule
module wave_mem_model (
    input  logic        clk_i,
    input  logic        rd_i,
    input  logic [15:0] addr_i,
    output logic        ready_o,
    output logic [7:0]  data_o
);
    timeunit 1ns;
    timeprecision 100ps;

    integer seed;
    int     wait_left;
    logic   pending;

    initial begin
        seed      = 32'h23d;
        wait_left = 0;
        pending   = 1'b0;
        ready_o   = 1'b0;
        data_o    = '0;
        forever begin
            @(posedge clk_i);
            #1;
            if (ready_o) begin
                // Reply was taken at this edge
                ready_o = 1'b0;
                pending = 1'b0;
            end else if (rd_i) begin
                if (!pending) begin
                    pending   = 1'b1;
                    wait_left = $unsigned($random(seed)) % 4;
                end
                if (wait_left == 0) begin
                    ready_o = 1'b1;
                    // Table 0xEE holds only end-of-table bytes
                    data_o  = (addr_i[15:8] == 8'hEE) ? 8'h00 : (addr_i[7:0] | 8'h01);
                end else begin
                    wait_left--;
                end
            end
        end
    end

endmodule

/* bench/tb_doc_synth.sv */
// Testbench for the wavetable generator
// Programs oscillators over the CPU bus and checks mixes, wave fetches and interrupts
`include "doc_macros.svh"

module tb_doc_synth
    import doc_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 4;
    localparam int OSC_N        = `DOC_OSC_COUNT;
    // Dispatch, ACCUM, up to 5 cycles of FETCH and SCALE
    localparam int SLOT_CYCLES  = 8;
    localparam int FRAME_BUDGET = 40;
    localparam int WATCHDOG_NS  = FRAME_BUDGET * SLOT_CYCLES * OSC_N * CLK_PERIOD + 4000;

    logic               clk;
    logic               arst_n;
    logic               clk_en;
    logic               cs_n;
    logic               we_n;
    logic [7:0]         addr;
    logic [7:0]         wdata;
    logic [7:0]         rdata;
    logic [15:0]        wave_addr;
    logic               wave_rd;
    logic               wave_ready;
    logic [7:0]         wave_data;
    logic               irq_n;
    logic signed [15:0] mono_mix;
    logic signed [15:0] left_mix;
    logic signed [15:0] right_mix;
    logic               frame;
    logic [4:0]         dbg_osc;
    osc_state_e         dbg_state;
    logic [7:0]         dbg_vol;
    logic [7:0]         dbg_wds;
    logic signed [15:0] dbg_out;

    // Mirror of the programmed registers
    logic [7:0] vol_sh [OSC_N];
    logic [7:0] ptr_sh [OSC_N];
    logic [4:0] ctrl_sh [OSC_N];
    logic [4:0] last_sh;
    logic [15:0] freq_f;

    // Check enables driven by the test sequence
    logic rst_chk;
    logic rd_chk;
    logic [7:0] rd_exp;
    logic [7:0] rd_mask;
    logic cfg_stable;
    logic mix_chk_en;
    logic addr_chk_en;
    logic irq_idle_chk;

    logic rd_chk_q;
    logic [7:0] rd_exp_q;
    logic [7:0] rd_mask_q;
    logic hold_q;
    logic [15:0] hold_addr_q;
    int read_k;
    logic [31:0] exp_phase;
    logic [7:0] exp_ptr;
    int sum_l;
    int sum_r;
    logic signed [15:0] exp_left;
    logic signed [15:0] exp_right;
    logic signed [15:0] exp_mono;

    // Expected debug snapshot of the slot being served
    logic [2:0]         dbg_idx;
    logic               dbg_silent;
    logic signed [15:0] exp_dbg_out;

    doc_synth_harness dut_i (
        .clk_i            (clk),
        .arst_n_i         (arst_n),
        .clk_en_i         (clk_en),
        .cs_n_i           (cs_n),
        .we_n_i           (we_n),
        .addr_i           (addr),
        .data_i           (wdata),
        .data_o           (rdata),
        .wave_address_o   (wave_addr),
        .wave_rd_o        (wave_rd),
        .wave_data_ready_i(wave_ready),
        .wave_data_i      (wave_data),
        .irq_n_o          (irq_n),
        .mono_mix_o       (mono_mix),
        .left_mix_o       (left_mix),
        .right_mix_o      (right_mix),
        .dbg_frame_o      (frame),
        .dbg_osc_o        (dbg_osc),
        .dbg_state_o      (dbg_state),
        .dbg_vol_o        (dbg_vol),
        .dbg_wds_o        (dbg_wds),
        .dbg_output_o     (dbg_out)
    );

    wave_mem_model wave_mem_i (
        .clk_i  (clk),
        .rd_i   (wave_rd),
        .addr_i (wave_addr),
        .ready_o(wave_ready),
        .data_o (wave_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic signed [15:0] clamp16(input int v);
        if (v > 32767) begin
            return 16'sh7FFF;
        end
        if (v < -32768) begin
            return 16'sh8000;
        end
        return 16'(v);
    endfunction

    // Every test voice reads sample byte 1, table 0xEE gives silence
    always_comb begin
        sum_l = 0;
        sum_r = 0;
        for (int i = 0; i < OSC_N; i++) begin
            if (i <= int'(last_sh) && !ctrl_sh[i][0] && ptr_sh[i] != 8'hEE) begin
                if (ctrl_sh[i][4]) begin
                    sum_r += (1 - 128) * int'(vol_sh[i]);
                end else begin
                    sum_l += (1 - 128) * int'(vol_sh[i]);
                end
            end
        end
        exp_left  = clamp16(sum_l);
        exp_right = clamp16(sum_r);
        exp_mono  = clamp16(sum_l + sum_r);
    end

    // k-th fetch of a fresh accumulator sits at k times the frequency
    assign exp_phase = 32'((read_k + 1) * int'(freq_f));
    assign exp_ptr   = ptr_sh[dbg_osc[2:0]];

    // Halted or end-of-table slots give a zero voice
    assign dbg_idx     = dbg_osc[2:0];
    assign dbg_silent  = ctrl_sh[dbg_idx][0] || ptr_sh[dbg_idx] == 8'hEE;
    assign exp_dbg_out = dbg_silent ? 16'sd0 : 16'((1 - 128) * int'(vol_sh[dbg_idx]));

    always @(posedge clk) begin
        rd_chk_q    <= rd_chk;
        rd_exp_q    <= rd_exp;
        rd_mask_q   <= rd_mask;
        hold_q      <= wave_rd && !wave_ready;
        hold_addr_q <= wave_addr;
        if (!addr_chk_en) begin
            read_k <= 0;
        end else if (wave_rd && wave_ready) begin
            read_k <= read_k + 1;
        end
    end

    task automatic report_mismatch(input string sig, input int exp_v, input int act_v);
        $display("[FAIL] %0t ns %s expected %0d actual %0d", $time, sig, exp_v, act_v);
        $display("*** FAILED ***");
        $fatal(1, "value check failed");
    endtask

    a_rst_irq: assert property (@(posedge clk) rst_chk |-> irq_n)
        else report_mismatch("irq_n_o", 1, $sampled(irq_n));
    a_rst_rd: assert property (@(posedge clk) rst_chk |-> !wave_rd)
        else report_mismatch("wave_rd_o", 0, $sampled(wave_rd));
    a_rst_mono: assert property (@(posedge clk) rst_chk |-> mono_mix == 0)
        else report_mismatch("mono_mix_o", 0, $sampled(mono_mix));
    a_rst_left: assert property (@(posedge clk) rst_chk |-> left_mix == 0)
        else report_mismatch("left_mix_o", 0, $sampled(left_mix));
    a_rst_right: assert property (@(posedge clk) rst_chk |-> right_mix == 0)
        else report_mismatch("right_mix_o", 0, $sampled(right_mix));

    a_readback: assert property (@(posedge clk) disable iff (!arst_n)
            rd_chk_q |-> (rdata & rd_mask_q) == rd_exp_q)
        else report_mismatch("data_o", $sampled(rd_exp_q), $sampled(rdata & rd_mask_q));

    // Strobe and address hold while memory stalls
    a_hold_rd: assert property (@(posedge clk) disable iff (!arst_n) hold_q |-> wave_rd)
        else report_mismatch("wave_rd_o", 1, $sampled(wave_rd));
    a_hold_addr: assert property (@(posedge clk) disable iff (!arst_n)
            hold_q |-> wave_addr == hold_addr_q)
        else report_mismatch("wave_address_o", $sampled(hold_addr_q), $sampled(wave_addr));

    a_table_ptr: assert property (@(posedge clk) disable iff (!arst_n)
            cfg_stable && wave_rd |-> wave_addr[15:8] == exp_ptr)
        else report_mismatch("wave_address_o[15:8]", $sampled(exp_ptr),
                             $sampled(wave_addr[15:8]));
    a_phase: assert property (@(posedge clk) disable iff (!arst_n)
            addr_chk_en && wave_rd && wave_ready |-> wave_addr[7:0] == exp_phase[23:16])
        else report_mismatch("wave_address_o[7:0]", $sampled(exp_phase[23:16]),
                             $sampled(wave_addr[7:0]));

    a_mix_left: assert property (@(posedge clk) disable iff (!arst_n)
            mix_chk_en && frame |-> left_mix == exp_left)
        else report_mismatch("left_mix_o", $sampled(exp_left), $sampled(left_mix));
    a_mix_right: assert property (@(posedge clk) disable iff (!arst_n)
            mix_chk_en && frame |-> right_mix == exp_right)
        else report_mismatch("right_mix_o", $sampled(exp_right), $sampled(right_mix));
    a_mix_mono: assert property (@(posedge clk) disable iff (!arst_n)
            mix_chk_en && frame |-> mono_mix == exp_mono)
        else report_mismatch("mono_mix_o", $sampled(exp_mono), $sampled(mono_mix));

    a_irq_idle: assert property (@(posedge clk) disable iff (!arst_n) irq_idle_chk |-> irq_n)
        else report_mismatch("irq_n_o", 1, $sampled(irq_n));

    // Debug snapshot follows the slot being served
    a_dbg_seq: assert property (@(posedge clk) disable iff (!arst_n)
            dbg_state == SCALE |=> dbg_state == NEXT)
        else report_mismatch("dbg_state_o", int'(NEXT), $sampled(dbg_state));
    a_dbg_vol: assert property (@(posedge clk) disable iff (!arst_n)
            cfg_stable && dbg_state != IDLE |-> dbg_vol == vol_sh[dbg_idx])
        else report_mismatch("dbg_vol_o", $sampled(vol_sh[dbg_idx]), $sampled(dbg_vol));
    a_dbg_wds: assert property (@(posedge clk) disable iff (!arst_n)
            mix_chk_en && dbg_state == NEXT && !dbg_silent |-> dbg_wds == 8'h01)
        else report_mismatch("dbg_wds_o", 1, $sampled(dbg_wds));
    a_dbg_out: assert property (@(posedge clk) disable iff (!arst_n)
            mix_chk_en && dbg_state == NEXT |-> dbg_out == exp_dbg_out)
        else report_mismatch("dbg_output_o", $sampled(exp_dbg_out), $sampled(dbg_out));

    // Bus tasks start and end 1 ns after a rising edge
    task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
        cs_n  = 1'b0;
        we_n  = 1'b0;
        addr  = a;
        wdata = d;
        @(posedge clk);
        #1;
        cs_n = 1'b1;
        we_n = 1'b1;
        case (a[7:5])
            3'd2:    vol_sh[a[2:0]] = d;
            3'd4:    ptr_sh[a[2:0]] = d;
            3'd5:    ctrl_sh[a[2:0]] = d[4:0];
            default: ;
        endcase
        if (a == 8'hE1) begin
            last_sh = d[4:0];
        end
    endtask

    task automatic bus_read(input logic [7:0] a, input logic [7:0] e, input logic [7:0] m);
        cs_n    = 1'b0;
        we_n    = 1'b1;
        addr    = a;
        rd_chk  = 1'b1;
        rd_exp  = e;
        rd_mask = m;
        @(posedge clk);
        #1;
        cs_n   = 1'b1;
        rd_chk = 1'b0;
        // Registered data is checked at this edge
        @(posedge clk);
        #1;
    endtask

    task automatic wait_frames(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            #1;
            if (frame) begin
                seen++;
            end
        end
    endtask

    task automatic wait_reads(input int n);
        while (read_k < n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_irq();
        while (irq_n) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        clk_en       = 1'b1;
        cs_n         = 1'b1;
        we_n         = 1'b1;
        addr         = '0;
        wdata        = '0;
        arst_n       = 1'b0;
        rst_chk      = 1'b0;
        rd_chk       = 1'b0;
        rd_exp       = '0;
        rd_mask      = '0;
        cfg_stable   = 1'b0;
        mix_chk_en   = 1'b0;
        addr_chk_en  = 1'b0;
        irq_idle_chk = 1'b0;
        freq_f       = '0;
        last_sh      = '0;
        for (int i = 0; i < OSC_N; i++) begin
            vol_sh[i]  = '0;
            ptr_sh[i]  = '0;
            ctrl_sh[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1 rst_chk = 1'b1;
        repeat (6) @(posedge clk);
        #1;
        rst_chk = 1'b0;
        arst_n  = 1'b1;

        // Read-back, halt lands first so osc 0 keeps a zero phase
        bus_write(8'hA0, 8'h15);
        bus_write(8'h00, 8'h5A);
        bus_write(8'h40, 8'hA5);
        bus_write(8'h80, 8'h3C);
        bus_write(8'hE1, 8'h03);
        bus_read(8'h00, 8'h5A, 8'hFF);
        bus_read(8'h40, 8'hA5, 8'hFF);
        bus_read(8'h80, 8'h3C, 8'hFF);
        bus_read(8'hA0, 8'h15, 8'hFF);
        bus_read(8'hE1, 8'h03, 8'hFF);
        bus_write(8'h00, 8'h00);

        // Two voices at sample 1, left and right
        bus_write(8'hE1, 8'h01);
        bus_write(8'h40, 8'h03);
        bus_write(8'h80, 8'h10);
        bus_write(8'hA0, 8'h00);
        bus_write(8'h41, 8'h05);
        bus_write(8'h81, 8'h20);
        bus_write(8'hA1, 8'h10);
        wait_frames(2);
        cfg_stable = 1'b1;
        mix_chk_en = 1'b1;
        wait_frames(3);
        // Halting osc 1 drops the right channel
        mix_chk_en = 1'b0;
        bus_write(8'hA1, 8'h11);
        wait_frames(2);
        mix_chk_en = 1'b1;
        wait_frames(3);

        // All slots at full volume saturate left and mono
        cfg_stable = 1'b0;
        mix_chk_en = 1'b0;
        bus_write(8'hE1, 8'h07);
        for (int i = 0; i < OSC_N; i++) begin
            bus_write(8'(8'h40 + i), 8'hFF);
            bus_write(8'(8'hA0 + i), 8'h00);
        end
        wait_frames(2);
        cfg_stable = 1'b1;
        mix_chk_en = 1'b1;
        wait_frames(3);

        // Phase stepping on one oscillator
        mix_chk_en = 1'b0;
        cfg_stable = 1'b0;
        bus_write(8'hE1, 8'h00);
        bus_write(8'hA0, 8'h01);
        wait_frames(2);
        freq_f = 16'hC000;
        bus_write(8'h00, 8'h00);
        bus_write(8'h20, 8'hC0);
        bus_write(8'h80, 8'h40);
        cfg_stable  = 1'b1;
        addr_chk_en = 1'b1;
        bus_write(8'hA0, 8'h00);
        wait_reads(12);
        addr_chk_en = 1'b0;

        // One-shot end of table with interrupt on osc 1
        bus_write(8'hA0, 8'h01);
        cfg_stable = 1'b0;
        bus_write(8'hE1, 8'h01);
        bus_write(8'hA1, 8'h01);
        bus_write(8'h81, 8'hEE);
        bus_write(8'h41, 8'h07);
        wait_frames(2);
        cfg_stable = 1'b1;
        mix_chk_en = 1'b1;
        bus_write(8'hA1, 8'h0A);
        wait_irq();
        bus_read(8'hA1, 8'h0B, 8'hFF);
        bus_read(8'hE0, 8'h01, 8'hFF);
        irq_idle_chk = 1'b1;
        bus_read(8'hE0, 8'h80, 8'h80);
        wait_frames(2);
        irq_idle_chk = 1'b0;

        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the test sequence did not complete", WATCHDOG_NS);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

/* files.f */
+incdir+rtl
rtl/doc_pkg.sv
rtl/doc_regfile.sv
rtl/doc_osc_sequencer.sv
rtl/doc_mixer.sv
rtl/doc_synth_harness.sv
bench/wave_mem_model.sv
bench/tb_doc_synth.sv

/* Bender.yml */
package:
  name: doc_synth

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/doc_pkg.sv
      - rtl/doc_regfile.sv
      - rtl/doc_osc_sequencer.sv
      - rtl/doc_mixer.sv
      - rtl/doc_synth_harness.sv
      - target: test
        files:
          - bench/wave_mem_model.sv
          - bench/tb_doc_synth.sv
